// File: src/spi_pkg.sv
// sclk idles at CLK_IDLE, enables are active low, and num_bits must be 1 to 32 or the write is refused
package spi_pkg;

    // apb register map, byte addresses
    localparam logic [7:0] SPI_ADDR_DIVIDER = 8'h00;
    localparam logic [7:0] SPI_ADDR_CONFIG  = 8'h04;
    // write loads tx and starts a transfer, read returns rx
    localparam logic [7:0] SPI_ADDR_DATA    = 8'h08;
    // bit0 is busy, everything else reads zero
    localparam logic [7:0] SPI_ADDR_STATUS  = 8'h0C;

    // number of slave enable lines brought out
    localparam int SEN_WIDTH = 8;

    // serial clock level between transfers
    localparam logic CLK_IDLE = 1'b0;

    // enables are active low, so all ones means nobody selected
    localparam logic [SEN_WIDTH-1:0] SEN_IDLE = {SEN_WIDTH{1'b1}};

    // configuration word, msb first
    // an edge bit that differs from CLK_IDLE means the edge where sclk leaves idle
    typedef struct packed {
        // edge that launches the next mosi bit
        logic        dataout_edge;
        // edge that samples miso
        logic        datain_edge;
        // transfer length, 1 to 32
        logic [5:0]  num_bits;
        // one bit per slave, only the low SEN_WIDTH bits reach the pins
        logic [23:0] slave_select;
    } spi_config_t;

    // phases of one transfer
    // wait is idle, pre and post pad the enables around the clock burst
    typedef enum logic [2:0] {
        phase_wait,
        phase_pre,
        phase_lead,
        phase_trail,
        phase_post
    } spi_phase_t;

    // single cycle strobes from the clock generator to the shift engine
    typedef struct packed {
        // entering pre, load tx and clear rx
        logic load;
        // sclk leaves its idle level at the coming edge
        logic lead;
        // sclk goes back to idle at the coming edge
        logic trail;
    } spi_strobe_t;

endpackage

// File: src/spi_apb_regs.sv
// apb slave with zero wait states; status writes are ignored, and config or divider writes are not blocked while busy
`timescale 1ns/1ns

module spi_apb_regs (
    input  logic                 clock,
    input  logic                 reset,
    // apb slave side
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    // from the clock generator and shift engine
    input  logic                 busy,
    input  logic [31:0]          rx_data,
    // register outputs
    output logic [15:0]          divider,
    output spi_pkg::spi_config_t cfg,
    output logic [31:0]          tx_data,
    output logic                 start
);

    // access phase of any transfer
    logic                 access;
    logic                 addr_known;
    // pwdata seen as a config word
    spi_pkg::spi_config_t wr_cfg;
    logic                 bad_bits;
    logic                 tx_refused;
    // write that passed every check
    logic                 wr_ok;

    // no wait states ever
    assign pready = 1'b1;

    assign access = psel && penable;

    assign addr_known = (paddr == spi_pkg::SPI_ADDR_DIVIDER) ||
                        (paddr == spi_pkg::SPI_ADDR_CONFIG)  ||
                        (paddr == spi_pkg::SPI_ADDR_DATA)    ||
                        (paddr == spi_pkg::SPI_ADDR_STATUS);

    assign wr_cfg = spi_pkg::spi_config_t'(pwdata);

    // legal lengths are 1 through 32
    assign bad_bits = (wr_cfg.num_bits == 6'd0) || (wr_cfg.num_bits > 6'd32);

    // a new tx word cannot replace one still being shifted
    assign tx_refused = busy && (paddr == spi_pkg::SPI_ADDR_DATA);

    // error is reported in the access phase only
    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            if (!addr_known) begin
                pslverr = 1'b1;
            end else if (pwrite && (paddr == spi_pkg::SPI_ADDR_CONFIG) && bad_bits) begin
                pslverr = 1'b1;
            end else if (pwrite && tx_refused) begin
                pslverr = 1'b1;
            end
        end
    end

    assign wr_ok = access && pwrite && !pslverr;

    // register writes land at the edge that closes the access phase
    always_ff @(posedge clock) begin
        if (reset) begin
            divider <= 16'd0;
            cfg     <= '0;
            tx_data <= 32'd0;
            start   <= 1'b0;
        end else begin
            // start is a one cycle pulse
            start <= 1'b0;
            if (wr_ok) begin
                case (paddr)
                    spi_pkg::SPI_ADDR_DIVIDER: begin
                        divider <= pwdata[15:0];
                    end
                    spi_pkg::SPI_ADDR_CONFIG: begin
                        cfg <= wr_cfg;
                    end
                    spi_pkg::SPI_ADDR_DATA: begin
                        tx_data <= pwdata;
                        // kicks the clock generator next cycle
                        start   <= 1'b1;
                    end
                    // status is read only
                    default: begin
                    end
                endcase
            end
        end
    end

    // read mux, valid whenever paddr is stable
    always_comb begin
        case (paddr)
            spi_pkg::SPI_ADDR_DIVIDER: prdata = {16'd0, divider};
            spi_pkg::SPI_ADDR_CONFIG:  prdata = cfg;
            spi_pkg::SPI_ADDR_DATA:    prdata = rx_data;
            spi_pkg::SPI_ADDR_STATUS:  prdata = {31'd0, busy};
            default:                   prdata = 32'd0;
        endcase
    end

    // pready is tied high, so a longer access phase would apply the same write twice
    a_access_one_cycle: assert property (
        @(posedge clock) disable iff (reset)
        (psel && penable) |=> !penable
    );

endmodule

// File: src/spi_sclk_gen.sv
// every phase lasts divider+1 cycles; changing divider or num_bits during a transfer is undefined
`timescale 1ns/1ns

module spi_sclk_gen (
    input  logic                 clock,
    input  logic                 reset,
    // one cycle pulse from the register block
    input  logic                 start,
    input  logic [15:0]          divider,
    input  spi_pkg::spi_config_t cfg,
    output logic                 busy,
    output logic                 sclk,
    output spi_pkg::spi_strobe_t strobe
);

    spi_pkg::spi_phase_t phase;

    // cycle counter inside one phase
    logic [15:0] div_count;
    logic [15:0] div_count_next;
    logic        count_done;

    // number of completed bits
    logic [5:0]  bit_count;
    logic        last_bit;

    logic        sclk_reg;

    assign count_done     = (div_count == divider);
    assign div_count_next = count_done ? 16'd0 : div_count + 16'd1;

    // current bit is the final one when its trail ends
    assign last_bit = ((bit_count + 6'd1) == cfg.num_bits);

    // busy from pre through post
    assign busy = (phase != spi_pkg::phase_wait);
    assign sclk = sclk_reg;

    // strobes mark the edge where the phase moves on
    assign strobe.load  = (phase == spi_pkg::phase_wait) && start;
    assign strobe.lead  = (phase == spi_pkg::phase_lead) && count_done;
    assign strobe.trail = (phase == spi_pkg::phase_trail) && count_done;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase     <= spi_pkg::phase_wait;
            div_count <= 16'd0;
            bit_count <= 6'd0;
            sclk_reg  <= spi_pkg::CLK_IDLE;
        end else begin
            case (phase)
                spi_pkg::phase_wait: begin
                    div_count <= 16'd0;
                    bit_count <= 6'd0;
                    sclk_reg  <= spi_pkg::CLK_IDLE;
                    if (start) begin
                        phase <= spi_pkg::phase_pre;
                    end
                end

                // enables settle before the first clock edge
                spi_pkg::phase_pre: begin
                    div_count <= div_count_next;
                    if (count_done) begin
                        phase <= spi_pkg::phase_lead;
                    end
                end

                // sclk sits idle here and leaves idle at the end
                spi_pkg::phase_lead: begin
                    div_count <= div_count_next;
                    if (count_done) begin
                        phase    <= spi_pkg::phase_trail;
                        sclk_reg <= ~spi_pkg::CLK_IDLE;
                    end
                end

                // sclk active here, back to idle at the end closes one bit
                spi_pkg::phase_trail: begin
                    div_count <= div_count_next;
                    if (count_done) begin
                        sclk_reg  <= spi_pkg::CLK_IDLE;
                        bit_count <= bit_count + 6'd1;
                        phase     <= last_bit ? spi_pkg::phase_post : spi_pkg::phase_lead;
                    end
                end

                // hold time after the last edge before enables drop
                spi_pkg::phase_post: begin
                    div_count <= div_count_next;
                    if (count_done) begin
                        phase <= spi_pkg::phase_wait;
                    end
                end

                default: begin
                    phase <= spi_pkg::phase_wait;
                end
            endcase
        end
    end

    // sclk only toggles inside the clock burst
    a_sclk_idle: assert property (
        @(posedge clock) disable iff (reset)
        !(phase inside {spi_pkg::phase_lead, spi_pkg::phase_trail}) |->
            (sclk == spi_pkg::CLK_IDLE)
    );

    // the register block must refuse tx writes while a transfer runs
    a_no_start_busy: assert property (
        @(posedge clock) disable iff (reset)
        start |-> !busy
    );

endmodule

// File: src/spi_shift_engine.sv
// msb first out, rx right aligned; launch on lead puts bit 31 on mosi at the first lead edge
`timescale 1ns/1ns

module spi_shift_engine (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          busy,
    input  spi_pkg::spi_strobe_t          strobe,
    input  spi_pkg::spi_config_t          cfg,
    input  logic [31:0]                   tx_data,
    // spi pins
    input  logic                          miso,
    output logic                          mosi,
    output logic [spi_pkg::SEN_WIDTH-1:0] sen,
    // right aligned receive word
    output logic [31:0]                   rx_data
);

    // one guard bit so a launch on lead still starts with bit 31
    logic [32:0] tx_shift;
    logic [31:0] rx_shift;

    // which sclk edge each direction uses
    logic launch_on_lead;
    logic sample_on_lead;
    logic launch;
    logic sample;

    // an edge bit unlike the idle level means the leaving edge
    assign launch_on_lead = (cfg.dataout_edge != spi_pkg::CLK_IDLE);
    assign sample_on_lead = (cfg.datain_edge != spi_pkg::CLK_IDLE);

    assign launch = launch_on_lead ? strobe.lead : strobe.trail;
    assign sample = sample_on_lead ? strobe.lead : strobe.trail;

    // top bit is always the one on the wire
    assign mosi    = tx_shift[32];
    assign rx_data = rx_shift;

    always_ff @(posedge clock) begin
        if (reset) begin
            tx_shift <= 33'd0;
            rx_shift <= 32'd0;
        end else if (strobe.load) begin
            // launch on lead shifts before the first sample, so park one bit low
            if (launch_on_lead) begin
                tx_shift <= {1'b0, tx_data};
            end else begin
                tx_shift <= {tx_data, 1'b0};
            end
            rx_shift <= 32'd0;
        end else begin
            if (launch) begin
                tx_shift <= {tx_shift[31:0], 1'b0};
            end
            // miso enters at bit 0, earlier bits move up
            if (sample) begin
                rx_shift <= {rx_shift[30:0], miso};
            end
        end
    end

    // enables follow busy by one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            sen <= spi_pkg::SEN_IDLE;
        end else if (busy) begin
            // flip the selected lines away from idle
            sen <= spi_pkg::SEN_IDLE ^ cfg.slave_select[spi_pkg::SEN_WIDTH-1:0];
        end else begin
            sen <= spi_pkg::SEN_IDLE;
        end
    end

    // both edges at once would shift twice in one cycle
    a_one_edge: assert property (
        @(posedge clock) disable iff (reset)
        !(strobe.lead && strobe.trail)
    );

endmodule

// File: src/spi_master.sv
// apb spi master top; one transfer at a time, up to 32 bits, SEN_WIDTH enables
`timescale 1ns/1ns

module spi_master (
    input  logic                          clock,
    input  logic                          reset,
    // apb slave port
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    // spi pins
    output logic                          sclk,
    output logic                          mosi,
    input  logic                          miso,
    output logic [spi_pkg::SEN_WIDTH-1:0] sen
);

    logic [15:0]          divider;
    spi_pkg::spi_config_t cfg;
    logic [31:0]          tx_data;
    logic [31:0]          rx_data;
    logic                 start;
    logic                 busy;
    spi_pkg::spi_strobe_t strobe;

    // registers and start pulse
    spi_apb_regs regs0 (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .busy    (busy),
        .rx_data (rx_data),
        .divider (divider),
        .cfg     (cfg),
        .tx_data (tx_data),
        .start   (start)
    );

    // bit timing, drives sclk and the strobes
    spi_sclk_gen clkgen0 (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .divider (divider),
        .cfg     (cfg),
        .busy    (busy),
        .sclk    (sclk),
        .strobe  (strobe)
    );

    // data path and enables
    spi_shift_engine shift0 (
        .clock   (clock),
        .reset   (reset),
        .busy    (busy),
        .strobe  (strobe),
        .cfg     (cfg),
        .tx_data (tx_data),
        .miso    (miso),
        .mosi    (mosi),
        .sen     (sen),
        .rx_data (rx_data)
    );

endmodule

// File: sim/spi_slave_model.sv
// behavioral slave; sel_n must be low only while an enable is active, and launch and sample edges must differ
`timescale 1ns/1ns

module spi_slave_model (
    input  logic        sclk,
    input  logic        mosi,
    input  logic        sel_n,
    // master launches on the edge where sclk leaves CLK_IDLE
    input  logic        launch_lead,
    input  logic [5:0]  num_bits,
    input  logic [31:0] reply,
    output logic        miso,
    // mosi bits in arrival order, last one at bit 0
    output logic [31:0] mosi_bits,
    output int          lead_count,
    output int          trail_count
);

    logic [31:0] out_word;
    logic        hold_first;
    logic        sel_prev;
    logic        sclk_prev;
    logic        is_lead;

    initial begin
        miso        = 1'b0;
        mosi_bits   = 32'd0;
        lead_count  = 0;
        trail_count = 0;
        hold_first  = 1'b0;
        out_word    = 32'd0;
        sel_prev    = 1'b1;
        sclk_prev   = spi_pkg::CLK_IDLE;
    end

    always @(sclk or sel_n) begin
        if (sel_n === 1'b0 && sel_prev !== 1'b0) begin
            // reply leaves msb first from the top of a left aligned word
            out_word    = reply << (32 - num_bits);
            miso        = out_word[31];
            hold_first  = launch_lead;
            mosi_bits   = 32'd0;
            lead_count  = 0;
            trail_count = 0;
        end else if (sel_n === 1'b0 && sclk !== sclk_prev) begin
            is_lead = (sclk !== spi_pkg::CLK_IDLE);
            if (is_lead) begin
                lead_count++;
            end else begin
                trail_count++;
            end
            if (is_lead == launch_lead) begin
                // with launch on lead the first bit is already out since select
                if (hold_first) begin
                    hold_first = 1'b0;
                end else begin
                    out_word = out_word << 1;
                    miso     = out_word[31];
                end
            end else begin
                // opposite edge is where the master samples, so mosi is stable here
                mosi_bits = {mosi_bits[30:0], mosi};
            end
        end
        sel_prev  = sel_n;
        sclk_prev = sclk;
    end

endmodule

// File: sim/spi_master_tb.sv
// apb is driven on falling edges; every row must launch and sample on opposite sclk edges
`timescale 1ns/1ns

module spi_master_tb;

    // one transfer per row
    typedef struct packed {
        logic [15:0]          divider;
        spi_pkg::spi_config_t cfg;
        logic [31:0]          tx;
        logic [31:0]          reply;
        // pslverr expected on the config write
        logic                 err;
    } row_t;

    logic                          clock;
    logic                          reset;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [7:0]                    paddr;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          sclk;
    logic                          mosi;
    logic                          miso;
    logic [spi_pkg::SEN_WIDTH-1:0] sen;

    // slave model hookup
    logic                          sel_n;
    logic                          launch_lead;
    logic [31:0]                   mosi_bits;
    int                            lead_count;
    int                            trail_count;

    row_t                          rows [7];
    row_t                          cur;
    spi_pkg::spi_config_t          good_cfg;
    logic [31:0]                   rd;
    logic [31:0]                   want;
    logic                          err;
    int                            n;
    int unsigned                   seed;

    // any active enable selects the one slave model
    assign sel_n       = &sen;
    assign launch_lead = (cur.cfg.dataout_edge != spi_pkg::CLK_IDLE);

    spi_master dut0 (.*);

    spi_slave_model slave0 (
        .sclk        (sclk),
        .mosi        (mosi),
        .sel_n       (sel_n),
        .launch_lead (launch_lead),
        .num_bits    (cur.cfg.num_bits),
        .reply       (cur.reply),
        .miso        (miso),
        .mosi_bits   (mosi_bits),
        .lead_count  (lead_count),
        .trail_count (trail_count)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("timed out waiting for %s", what);
        $display("FAIL: see errors above");
        $fatal(1, "wait limit reached");
    endtask

    // setup cycle then one access cycle, pready is expected high
    task automatic apb_access(input logic is_write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        // sample mid cycle, well clear of the closing edge
        #1;
        check_value(pready, 1'b1, "pready in access phase");
        rdata  = prdata;
        slverr = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] ignored;
        apb_access(1'b1, addr, data, ignored, slverr);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_access(1'b0, addr, 32'd0, data, slverr);
    endtask

    // step falling edges until sen leaves idle, or returns to it
    task automatic wait_sen(input logic active, input string what);
        int cycles;
        cycles = 0;
        while ((sen === spi_pkg::SEN_IDLE) == active) begin
            @(negedge clock);
            cycles++;
            if (cycles > 64) begin
                timed_out(what);
            end
        end
    endtask

    // poll status bit0 until the transfer is over
    task automatic wait_idle();
        logic [31:0] status;
        logic        status_err;
        int          polls;
        polls = 0;
        apb_read(spi_pkg::SPI_ADDR_STATUS, status, status_err);
        check_value(status_err, 1'b0, "pslverr on status read");
        while (status[0] !== 1'b0) begin
            polls++;
            if (polls > 1000) begin
                timed_out("status busy to clear");
            end
            apb_read(spi_pkg::SPI_ADDR_STATUS, status, status_err);
            check_value(status_err, 1'b0, "pslverr on status read");
        end
    endtask

    initial begin
        seed = 32'he91a_d2a1;
        void'($urandom(seed));
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 8'd0;
        pwdata   = 32'd0;
        cur      = '0;
        good_cfg = '0;
        // divider, out edge, in edge, num_bits, slave_select, tx, reply, config error
        rows[0] = {16'd0, 1'b0, 1'b1, 6'd8, 24'h000001, 32'ha500_0000, 32'h0000_003c, 1'b0};
        rows[1] = {16'd2, 1'b1, 1'b0, 6'd1, 24'h000080, $urandom, $urandom, 1'b0};
        rows[2] = {16'd1, 1'b0, 1'b1, 6'd17, 24'h000005, $urandom, $urandom, 1'b0};
        rows[3] = {16'd3, 1'b1, 1'b0, 6'd32, 24'h0000f0, $urandom, $urandom, 1'b0};
        // select bits above SEN_WIDTH never reach the pins
        rows[4] = {16'd0, 1'b0, 1'b1, 6'd32, 24'h300002, $urandom, $urandom, 1'b0};
        rows[5] = {16'd1, 1'b0, 1'b1, 6'd0, 24'h000001, 32'd0, 32'd0, 1'b1};
        rows[6] = {16'd1, 1'b1, 1'b0, 6'd33, 24'h000001, 32'd0, 32'd0, 1'b1};
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        apb_read(spi_pkg::SPI_ADDR_STATUS, rd, err);
        check_value(rd, 32'd0, "status after reset");
        apb_read(spi_pkg::SPI_ADDR_CONFIG, rd, err);
        check_value(rd, 32'd0, "config after reset");
        check_value(sclk, spi_pkg::CLK_IDLE, "sclk after reset");
        check_value(sen, spi_pkg::SEN_IDLE, "sen after reset");
        apb_read(8'h10, rd, err);
        check_value(err, 1'b1, "pslverr on unknown read");
        apb_write(8'h20, 32'hffff_ffff, err);
        check_value(err, 1'b1, "pslverr on unknown write");

        for (int i = 0; i < $size(rows); i++) begin
            cur = rows[i];
            apb_write(spi_pkg::SPI_ADDR_DIVIDER, {16'd0, cur.divider}, err);
            check_value(err, 1'b0, "pslverr on divider write");
            apb_write(spi_pkg::SPI_ADDR_CONFIG, cur.cfg, err);
            check_value(err, cur.err, "pslverr on config write");
            if (cur.err) begin
                // refused length keeps the last good config
                apb_read(spi_pkg::SPI_ADDR_CONFIG, rd, err);
                check_value(rd, good_cfg, "config after refused write");
            end else begin
                good_cfg = cur.cfg;
                n        = cur.cfg.num_bits;
                apb_write(spi_pkg::SPI_ADDR_DATA, cur.tx, err);
                check_value(err, 1'b0, "pslverr on tx write");
                wait_sen(1'b1, "enables to go active");
                check_value(sen, spi_pkg::SEN_IDLE & ~cur.cfg.slave_select[7:0], "sen while busy");
                // a second word mid transfer is refused and must not disturb the first
                apb_write(spi_pkg::SPI_ADDR_DATA, ~cur.tx, err);
                check_value(err, 1'b1, "pslverr on tx write while busy");
                wait_idle();
                wait_sen(1'b0, "enables to return idle");
                want = (n == 32) ? cur.reply : (cur.reply & ((32'd1 << n) - 32'd1));
                apb_read(spi_pkg::SPI_ADDR_DATA, rd, err);
                check_value(rd, want, "rx data right aligned");
                check_value(mosi_bits, cur.tx >> (32 - n), "mosi bits seen by slave");
                check_value(lead_count, n, "sclk lead edges");
                check_value(trail_count, n, "sclk trail edges");
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: spi_master.f
src/spi_pkg.sv
src/spi_apb_regs.sv
src/spi_sclk_gen.sv
src/spi_shift_engine.sv
src/spi_master.sv
sim/spi_slave_model.sv
sim/spi_master_tb.sv
